//--- src.f
logic/core_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/prefetch_fifo.sv
logic/instr_fetch.sv
logic/load_store.sv
logic/exec_control.sv
logic/core_top.sv
sim/mem_model.sv
sim/core_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f src.f -o core_tb
	out="$$(./obj_dir/core_tb)"; echo "$$out"; echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

//--- sim/core_tb.sv
`timescale 1ns/1ns

module core_tb;

    typedef enum logic [1:0] {
        k_alu,
        k_move,
        k_load,
        k_pad
    } row_kind_t;

    typedef struct packed {
        row_kind_t   kind;
        logic [7:0]  op;
        logic [15:0] a;
        logic [15:0] b;
        logic [2:0]  rnum;
        logic [15:0] expected;
    } row_t;

    logic             clk;
    logic             rst_n;
    core_pkg::waddr_t instr_addr;
    logic             instr_access;
    core_pkg::word_t  instr_data;
    logic             instr_ack;
    core_pkg::waddr_t data_addr;
    core_pkg::word_t  data_wdata;
    core_pkg::word_t  data_rdata;
    logic             data_access;
    logic             data_wr_en;
    logic             data_ack;
    logic             halted;

    row_t             rows [$];
    logic [7:0]       prog_q [$];
    int               errors = 0;
    int               checks = 0;
    int               cycles = 0;
    int               cycle_limit = 0;
    core_pkg::waddr_t fetch_next = '0;

    core_top u_core_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_addr   (instr_addr),
        .instr_access (instr_access),
        .instr_data   (instr_data),
        .instr_ack    (instr_ack),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata),
        .data_access  (data_access),
        .data_wr_en   (data_wr_en),
        .data_ack     (data_ack),
        .halted       (halted)
    );

    mem_model u_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_addr   (instr_addr),
        .instr_access (instr_access),
        .instr_data   (instr_data),
        .instr_ack    (instr_ack),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata),
        .data_access  (data_access),
        .data_wr_en   (data_wr_en),
        .data_ack     (data_ack)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            errors++;
            $display("Timeout after %0d cycles, the core never finished its program", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Fetch address starts at 0, steps by one per ack and holds until the ack
    always @(negedge clk) begin
        if (!rst_n) begin
            fetch_next = '0;
        end else if (instr_access) begin
            assert (instr_addr == fetch_next) else begin
                errors++;
                $display("Fail %0t instr_addr expected %h got %h", $time, fetch_next, instr_addr);
            end
            if (instr_ack)
                fetch_next = fetch_next + 1'b1;
        end
    end

    always @(negedge clk) begin
        if (rst_n && halted) begin
            assert (!data_access) else begin
                errors++;
                $display("Fail %0t data_access expected 0 got 1 after halt", $time);
            end
        end
    end

    function automatic logic [15:0] alu_expect(input logic [7:0] op, input logic [15:0] a,
                                               input logic [15:0] b);
        case (op)
            8'h05:   return a + b;
            8'h2d:   return a - b;
            8'h25:   return a & b;
            8'h0d:   return a | b;
            8'h35:   return a ^ b;
            default: return b;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("Fail %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic add_row(input row_kind_t kind, input logic [7:0] op, input logic [15:0] a,
                           input logic [15:0] b, input logic [2:0] rnum,
                           input logic [15:0] expected);
        rows.push_back(row_t'{kind, op, a, b, rnum, expected});
    endtask

    task automatic fill_table();
        logic [7:0]  alu_ops [5];
        logic [7:0]  op;
        logic [15:0] a;
        logic [15:0] b;
        int          i;
        alu_ops = '{8'h05, 8'h2d, 8'h25, 8'h0d, 8'h35};
        add_row(k_alu, 8'h05, 16'h1234, 16'h0fff, 3'd0, 16'h2233);
        add_row(k_alu, 8'h05, 16'hffff, 16'h0002, 3'd0, 16'h0001);
        add_row(k_alu, 8'h2d, 16'h1000, 16'h0001, 3'd0, 16'h0fff);
        add_row(k_alu, 8'h2d, 16'h0003, 16'h0005, 3'd0, 16'hfffe);
        add_row(k_alu, 8'h25, 16'hf0f0, 16'h3c3c, 3'd0, 16'h3030);
        add_row(k_alu, 8'h0d, 16'hf000, 16'h00a5, 3'd0, 16'hf0a5);
        add_row(k_alu, 8'h35, 16'haaaa, 16'h0ff0, 3'd0, 16'ha55a);
        // Each register is loaded and copied to AX
        for (i = 1; i < 8; i++) begin
            a = 16'(i * 16'h1357) ^ 16'h8000;
            add_row(k_move, 8'h89, a, 16'h0000, 3'(i), a);
        end
        add_row(k_load, 8'ha1, 16'h7fff, 16'h0000, 3'd0, 16'h8000);
        add_row(k_load, 8'ha1, 16'hffff, 16'h0000, 3'd0, 16'h0000);
        add_row(k_pad, 8'h35, 16'h1234, 16'h00ff, 3'd0, 16'h12cb);
        add_row(k_pad, 8'h2d, 16'h0100, 16'h0200, 3'd0, 16'hff00);
        for (i = 0; i < 8; i++) begin
            op = alu_ops[$urandom_range(4, 0)];
            a  = 16'($urandom);
            b  = 16'($urandom);
            add_row(k_alu, op, a, b, 3'd0, alu_expect(op, a, b));
        end
    endtask

    task automatic word_bytes(input logic [15:0] w);
        prog_q.push_back(w[7:0]);
        prog_q.push_back(w[15:8]);
    endtask

    task automatic mov_imm_code(input logic [2:0] rnum, input logic [15:0] w);
        prog_q.push_back({5'b10111, rnum});
        word_bytes(w);
    endtask

    task automatic store_ax_code(input logic [7:0] addr_lo);
        prog_q.push_back(8'ha3);
        word_bytes({8'h00, addr_lo});
    endtask

    task automatic build_program(input row_t r);
        prog_q.delete();
        case (r.kind)
            k_move: begin
                mov_imm_code(r.rnum, r.a);
                prog_q.push_back(8'h89);
                prog_q.push_back({2'b11, r.rnum, 3'b000});
                store_ax_code(8'h42);
            end
            k_load: begin
                prog_q.push_back(8'ha1);
                word_bytes(16'h0060);
                prog_q.push_back(8'h05);
                word_bytes(16'h0001);
                store_ax_code(8'h62);
            end
            default: begin
                if (r.kind == k_pad)
                    prog_q.push_back(8'h90);
                mov_imm_code(3'd0, r.a);
                // Unknown opcode, then an 89 with a memory-mode ModR/M
                if (r.kind == k_pad) begin
                    prog_q.push_back(8'h40);
                    prog_q.push_back(8'h89);
                    prog_q.push_back(8'h07);
                end
                prog_q.push_back(r.op);
                word_bytes(r.b);
                if (r.kind == k_pad)
                    prog_q.push_back(8'h90);
                store_ax_code(8'h40);
            end
        endcase
        prog_q.push_back(8'hf4);
    endtask

    task automatic run_row(input int idx, input row_t r);
        core_pkg::waddr_t exp_addr;
        int               nwr;
        int               i;
        case (r.kind)
            k_move:  exp_addr = 15'h21;
            k_load:  exp_addr = 15'h31;
            default: exp_addr = 15'h20;
        endcase
        build_program(r);
        @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        for (i = 0; i < 256; i++)
            u_mem.prog[i] = (i < prog_q.size()) ? prog_q[i] : 8'hf4;
        if (r.kind == k_load)
            u_mem.ram[8'h30] = r.a;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        while (!halted)
            @(negedge clk);
        // Watch past the halt for stray bus activity
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
            assert (halted) else begin
                errors++;
                $display("Fail %0t halted expected 1 got 0 before reset", $time);
            end
        end
        nwr = u_mem.wr_addr_q.size();
        check_word($sformatf("row %0d data write count", idx), 16'd1, 16'(nwr));
        if (nwr > 0) begin
            check_word($sformatf("row %0d data_addr", idx), {1'b0, exp_addr},
                       {1'b0, u_mem.wr_addr_q[0]});
            check_word($sformatf("row %0d data_wdata", idx), r.expected, u_mem.wr_data_q[0]);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        void'($urandom(32'h5a68_05e6));
        fill_table();
        cycle_limit = rows.size() * 300;
        foreach (rows[i])
            run_row(i, rows[i]);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- sim/mem_model.sv
`timescale 1ns/1ns

module mem_model (
    input  logic             clk,
    input  logic             rst_n,
    input  core_pkg::waddr_t instr_addr,
    input  logic             instr_access,
    output core_pkg::word_t  instr_data,
    output logic             instr_ack,
    input  core_pkg::waddr_t data_addr,
    input  core_pkg::word_t  data_wdata,
    output core_pkg::word_t  data_rdata,
    input  logic             data_access,
    input  logic             data_wr_en,
    output logic             data_ack
);

    logic [7:0]       prog [256];
    core_pkg::word_t  ram [256];
    core_pkg::waddr_t wr_addr_q [$];
    core_pkg::word_t  wr_data_q [$];
    logic [1:0]       i_wait;
    logic [1:0]       d_wait;
    logic             i_busy;
    logic             d_busy;

    initial begin
        int i;
        instr_data = '0;
        instr_ack  = 1'b0;
        data_rdata = '0;
        data_ack   = 1'b0;
        i_busy     = 1'b0;
        d_busy     = 1'b0;
        i_wait     = '0;
        d_wait     = '0;
        // Unused program bytes read as HLT
        for (i = 0; i < 256; i++) begin
            prog[i] = 8'hf4;
            ram[i]  = {8'(i) ^ 8'h3c, 8'(i)};
        end
    end

    // Instruction ROM, byte pair at the word address
    always @(posedge clk) begin
        instr_ack <= 1'b0;
        if (!rst_n) begin
            i_busy <= 1'b0;
        end else if (instr_access && !instr_ack) begin
            if (!i_busy) begin
                i_busy <= 1'b1;
                i_wait <= 2'($urandom_range(3, 0));
            end else if (i_wait == 2'd0) begin
                i_busy     <= 1'b0;
                instr_ack  <= 1'b1;
                instr_data <= {prog[{instr_addr[7:1], 1'b1}], prog[{instr_addr[7:1], 1'b0}]};
            end else begin
                i_wait <= i_wait - 1'b1;
            end
        end
    end

    // Data RAM, every store is logged in order
    always @(posedge clk) begin
        data_ack <= 1'b0;
        if (!rst_n) begin
            d_busy <= 1'b0;
            wr_addr_q.delete();
            wr_data_q.delete();
        end else if (data_access && !data_ack) begin
            if (!d_busy) begin
                d_busy <= 1'b1;
                d_wait <= 2'($urandom_range(3, 0));
            end else if (d_wait == 2'd0) begin
                d_busy   <= 1'b0;
                data_ack <= 1'b1;
                if (data_wr_en) begin
                    ram[data_addr[8:1]] <= data_wdata;
                    wr_addr_q.push_back(data_addr);
                    wr_data_q.push_back(data_wdata);
                end else begin
                    data_rdata <= ram[data_addr[8:1]];
                end
            end else begin
                d_wait <= d_wait - 1'b1;
            end
        end
    end

endmodule

//--- logic/core_top.sv
`timescale 1ns/1ns

module core_top (
    input  logic              clk,
    input  logic              rst_n,
    output core_pkg::waddr_t  instr_addr,
    output logic              instr_access,
    input  core_pkg::word_t   instr_data,
    input  logic              instr_ack,
    output core_pkg::waddr_t  data_addr,
    output core_pkg::word_t   data_wdata,
    input  core_pkg::word_t   data_rdata,
    output logic              data_access,
    output logic              data_wr_en,
    input  logic              data_ack,
    output logic              halted
);

    logic                        fifo_wr_en;
    logic [core_pkg::byte_w-1:0] fifo_wr_data;
    logic                        fifo_nearly_full;
    logic                        fifo_rd_en;
    core_pkg::fifo_out_t         head;

    core_pkg::reg_idx_t          reg_rd_sel;
    core_pkg::word_t             reg_rd_val;
    core_pkg::reg_wr_t           reg_wr;

    core_pkg::alu_op_t           alu_op;
    core_pkg::word_t             alu_b;
    core_pkg::word_t             alu_result;

    logic                        ls_start;
    core_pkg::ls_req_t           ls_req;
    logic                        ls_done;
    core_pkg::word_t             ls_rdata;

    // Input side
    instr_fetch u_instr_fetch (
        .clk              (clk),
        .rst_n            (rst_n),
        .instr_addr       (instr_addr),
        .instr_access     (instr_access),
        .instr_data       (instr_data),
        .instr_ack        (instr_ack),
        .fifo_nearly_full (fifo_nearly_full),
        .fifo_wr_en       (fifo_wr_en),
        .fifo_wr_data     (fifo_wr_data)
    );

    prefetch_fifo u_prefetch_fifo (
        .clk              (clk),
        .rst_n            (rst_n),
        .fifo_wr_en       (fifo_wr_en),
        .fifo_wr_data     (fifo_wr_data),
        .fifo_rd_en       (fifo_rd_en),
        .head             (head),
        .fifo_nearly_full (fifo_nearly_full)
    );

    // Processing
    exec_control u_exec_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .head       (head),
        .fifo_rd_en (fifo_rd_en),
        .reg_rd_sel (reg_rd_sel),
        .reg_rd_val (reg_rd_val),
        .alu_op     (alu_op),
        .alu_b      (alu_b),
        .alu_result (alu_result),
        .reg_wr     (reg_wr),
        .ls_start   (ls_start),
        .ls_req     (ls_req),
        .ls_done    (ls_done),
        .ls_rdata   (ls_rdata),
        .halted     (halted)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_rd_sel (reg_rd_sel),
        .reg_rd_val (reg_rd_val),
        .reg_wr     (reg_wr)
    );

    alu u_alu (
        .alu_op     (alu_op),
        .alu_a      (reg_rd_val),
        .alu_b      (alu_b),
        .alu_result (alu_result)
    );

    // Output side
    load_store u_load_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .ls_start    (ls_start),
        .ls_req      (ls_req),
        .ls_done     (ls_done),
        .ls_rdata    (ls_rdata),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_rdata  (data_rdata),
        .data_access (data_access),
        .data_wr_en  (data_wr_en),
        .data_ack    (data_ack)
    );

endmodule

//--- logic/exec_control.sv
`timescale 1ns/1ns

module exec_control (
    input  logic                   clk,
    input  logic                   rst_n,
    input  core_pkg::fifo_out_t    head,
    output logic                   fifo_rd_en,
    output core_pkg::reg_idx_t     reg_rd_sel,
    input  core_pkg::word_t        reg_rd_val,
    output core_pkg::alu_op_t      alu_op,
    output core_pkg::word_t        alu_b,
    input  core_pkg::word_t        alu_result,
    output core_pkg::reg_wr_t      reg_wr,
    output logic                   ls_start,
    output core_pkg::ls_req_t      ls_req,
    input  logic                   ls_done,
    input  core_pkg::word_t        ls_rdata,
    output logic                   halted
);

    typedef enum logic [2:0] {
        st_opcode,
        st_modrm,
        st_imm_lo,
        st_imm_hi,
        st_execute,
        st_mem_wait,
        st_halt
    } ctrl_state_t;

    ctrl_state_t          state;
    core_pkg::opcode_t    opcode;
    core_pkg::reg_idx_t   dst;
    core_pkg::reg_idx_t   src;
    core_pkg::word_t      imm;
    logic                 is_mem_op;

    assign is_mem_op = (opcode == core_pkg::op_mov_ax_mem) || (opcode == core_pkg::op_mov_mem_ax);
    assign halted    = (state == st_halt);

    // Memory operand address comes from the immediate, store data from AX
    assign ls_req.addr  = imm;
    assign ls_req.wdata = reg_rd_val;
    assign ls_req.write = (opcode == core_pkg::op_mov_mem_ax);

    always_comb begin
        fifo_rd_en = 1'b0;
        reg_rd_sel = core_pkg::reg_idx_t'(core_pkg::reg_ax);
        alu_op     = core_pkg::alu_pass_b;
        alu_b      = imm;
        reg_wr     = '0;
        ls_start   = 1'b0;
        case (state)
            st_opcode, st_modrm, st_imm_lo, st_imm_hi: fifo_rd_en = !head.empty;
            st_execute: begin
                case (opcode)
                    core_pkg::op_add_ax: alu_op = core_pkg::alu_add;
                    core_pkg::op_sub_ax: alu_op = core_pkg::alu_sub;
                    core_pkg::op_and_ax: alu_op = core_pkg::alu_and;
                    core_pkg::op_or_ax:  alu_op = core_pkg::alu_or;
                    core_pkg::op_xor_ax: alu_op = core_pkg::alu_xor;
                    core_pkg::op_mov_rm_r: begin
                        reg_rd_sel = src;
                        alu_b      = reg_rd_val;
                    end
                    default: alu_op = core_pkg::alu_pass_b;
                endcase
                ls_start     = is_mem_op;
                reg_wr.en    = !is_mem_op;
                reg_wr.idx   = dst;
                reg_wr.data  = alu_result;
            end
            st_mem_wait: begin
                reg_wr.en   = ls_done && (opcode == core_pkg::op_mov_ax_mem);
                reg_wr.idx  = dst;
                reg_wr.data = ls_rdata;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_opcode;
        end else begin
            case (state)
                st_opcode: begin
                    if (!head.empty) begin
                        if (head.data[7:3] == core_pkg::op_mov_imm_base[7:3]) begin
                            state <= st_imm_lo;
                        end else begin
                            case (head.data)
                                core_pkg::op_add_ax, core_pkg::op_sub_ax,
                                core_pkg::op_and_ax, core_pkg::op_or_ax,
                                core_pkg::op_xor_ax, core_pkg::op_mov_ax_mem,
                                core_pkg::op_mov_mem_ax: state <= st_imm_lo;
                                core_pkg::op_mov_rm_r:   state <= st_modrm;
                                core_pkg::op_hlt:        state <= st_halt;
                                core_pkg::op_nop:        state <= st_opcode;
                                default:                 state <= st_opcode;
                            endcase
                        end
                    end
                end
                st_modrm: begin
                    // Only register mode is executed
                    if (!head.empty)
                        state <= (head.data[7:6] == 2'b11) ? st_execute : st_opcode;
                end
                st_imm_lo: begin
                    if (!head.empty)
                        state <= st_imm_hi;
                end
                st_imm_hi: begin
                    if (!head.empty)
                        state <= st_execute;
                end
                st_execute:  state <= is_mem_op ? st_mem_wait : st_opcode;
                st_mem_wait: begin
                    if (ls_done)
                        state <= st_opcode;
                end
                default: state <= st_halt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_opcode && !head.empty) begin
            if (head.data[7:3] == core_pkg::op_mov_imm_base[7:3]) begin
                opcode <= core_pkg::op_mov_imm_base;
                dst    <= head.data[2:0];
            end else begin
                opcode <= core_pkg::opcode_t'(head.data);
                dst    <= core_pkg::reg_idx_t'(core_pkg::reg_ax);
            end
        end
        if (state == st_modrm && !head.empty) begin
            dst <= head.data[2:0];
            src <= head.data[5:3];
        end
        if (state == st_imm_lo && !head.empty)
            imm[7:0] <= head.data;
        if (state == st_imm_hi && !head.empty)
            imm[15:8] <= head.data;
    end

    // One outstanding memory request at a time
    a_single_req: assert property (@(posedge clk) disable iff (!rst_n)
        ls_start |=> state == st_mem_wait && !ls_start);

endmodule

//--- logic/load_store.sv
`timescale 1ns/1ns

module load_store (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ls_start,
    input  core_pkg::ls_req_t   ls_req,
    output logic                ls_done,
    output core_pkg::word_t     ls_rdata,
    output core_pkg::waddr_t    data_addr,
    output core_pkg::word_t     data_wdata,
    input  core_pkg::word_t     data_rdata,
    output logic                data_access,
    output logic                data_wr_en,
    input  logic                data_ack
);

    typedef enum logic {
        ls_idle,
        ls_busy
    } ls_state_t;

    ls_state_t state;

    assign data_access = (state == ls_busy);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ls_idle;
            data_wr_en <= 1'b0;
            ls_done    <= 1'b0;
        end else begin
            ls_done <= 1'b0;
            case (state)
                ls_idle: begin
                    if (ls_start) begin
                        state      <= ls_busy;
                        data_wr_en <= ls_req.write;
                    end
                end
                ls_busy: begin
                    if (data_ack) begin
                        state      <= ls_idle;
                        data_wr_en <= 1'b0;
                        ls_done    <= 1'b1;
                    end
                end
                default: state <= ls_idle;
            endcase
        end
    end

    // Bus payload held from start until the ack
    always_ff @(posedge clk) begin
        if (state == ls_idle && ls_start) begin
            data_addr  <= ls_req.addr[core_pkg::data_w-1:1];
            data_wdata <= ls_req.wdata;
        end
        if (state == ls_busy && data_ack)
            ls_rdata <= data_rdata;
    end

    a_hold_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(data_access) |-> $past(data_ack));

endmodule

//--- logic/instr_fetch.sv
`timescale 1ns/1ns

module instr_fetch (
    input  logic                        clk,
    input  logic                        rst_n,
    output core_pkg::waddr_t            instr_addr,
    output logic                        instr_access,
    input  core_pkg::word_t             instr_data,
    input  logic                        instr_ack,
    input  logic                        fifo_nearly_full,
    output logic                        fifo_wr_en,
    output logic [core_pkg::byte_w-1:0] fifo_wr_data
);

    typedef enum logic [1:0] {
        fs_idle,
        fs_access,
        fs_high_byte
    } fetch_state_t;

    fetch_state_t state;
    logic [core_pkg::byte_w-1:0] hi_byte;

    assign instr_access = (state == fs_access);

    // Low byte goes straight in at the ack, high byte one cycle later
    assign fifo_wr_en   = (state == fs_access && instr_ack) || (state == fs_high_byte);
    assign fifo_wr_data = (state == fs_access) ? instr_data[core_pkg::byte_w-1:0] : hi_byte;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= fs_idle;
            instr_addr <= '0;
        end else begin
            case (state)
                fs_idle: begin
                    if (!fifo_nearly_full)
                        state <= fs_access;
                end
                fs_access: begin
                    if (instr_ack) begin
                        state      <= fs_high_byte;
                        instr_addr <= instr_addr + 1'b1;
                    end
                end
                default: state <= fs_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fs_access && instr_ack)
            hi_byte <= instr_data[core_pkg::data_w-1:core_pkg::byte_w];
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        instr_access && !instr_ack |=> instr_access && $stable(instr_addr));

    // Room for both bytes must exist before the bus is requested
    a_start_room: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(instr_access) |-> !$past(fifo_nearly_full));

endmodule

//--- logic/prefetch_fifo.sv
`timescale 1ns/1ns

module prefetch_fifo (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        fifo_wr_en,
    input  logic [core_pkg::byte_w-1:0] fifo_wr_data,
    input  logic                        fifo_rd_en,
    output core_pkg::fifo_out_t         head,
    output logic                        fifo_nearly_full
);

    logic [core_pkg::byte_w-1:0] mem [core_pkg::fifo_depth];
    logic [$clog2(core_pkg::fifo_depth)-1:0] rd_ptr;
    logic [$clog2(core_pkg::fifo_depth)-1:0] wr_ptr;
    logic [$clog2(core_pkg::fifo_depth+1)-1:0] count;
    logic do_rd;

    assign do_rd = fifo_rd_en && (count != 0);

    assign head.data        = mem[rd_ptr];
    assign head.empty       = (count == 0);
    assign fifo_nearly_full = (count > core_pkg::fifo_depth - 2);

    always_ff @(posedge clk) begin
        if (fifo_wr_en)
            mem[wr_ptr] <= fifo_wr_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (fifo_wr_en)
                wr_ptr <= (wr_ptr == core_pkg::fifo_depth - 1) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == core_pkg::fifo_depth - 1) ? '0 : rd_ptr + 1'b1;
            case ({fifo_wr_en, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_wr_en |-> count != core_pkg::fifo_depth);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_rd_en |-> count != 0);

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::reg_idx_t  reg_rd_sel,
    output core_pkg::word_t     reg_rd_val,
    input  core_pkg::reg_wr_t   reg_wr
);

    core_pkg::word_t regs [8];

    assign reg_rd_val = regs[reg_rd_sel];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end else if (reg_wr.en) begin
            regs[reg_wr.idx] <= reg_wr.data;
        end
    end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ns

module alu (
    input  core_pkg::alu_op_t  alu_op,
    input  core_pkg::word_t    alu_a,
    input  core_pkg::word_t    alu_b,
    output core_pkg::word_t    alu_result
);

    // Results wrap at 16 bits, no flags are kept
    always_comb begin
        case (alu_op)
            core_pkg::alu_add:    alu_result = alu_a + alu_b;
            core_pkg::alu_sub:    alu_result = alu_a - alu_b;
            core_pkg::alu_and:    alu_result = alu_a & alu_b;
            core_pkg::alu_or:     alu_result = alu_a | alu_b;
            core_pkg::alu_xor:    alu_result = alu_a ^ alu_b;
            core_pkg::alu_pass_b: alu_result = alu_b;
            default:              alu_result = alu_b;
        endcase
    end

endmodule

//--- logic/core_pkg.sv
package core_pkg;

    localparam int data_w = 16;
    localparam int byte_w = 8;
    localparam int fifo_depth = 6;
    localparam int reg_ax = 0;

    typedef logic [data_w-1:0] word_t;

    // Bits 15 to 1 of a byte address
    typedef logic [data_w-1:1] waddr_t;

    typedef logic [2:0] reg_idx_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

    // B8 stands for the whole B8..BF group
    typedef enum logic [7:0] {
        op_mov_imm_base = 8'hb8,
        op_add_ax       = 8'h05,
        op_sub_ax       = 8'h2d,
        op_and_ax       = 8'h25,
        op_or_ax        = 8'h0d,
        op_xor_ax       = 8'h35,
        op_mov_rm_r     = 8'h89,
        op_mov_ax_mem   = 8'ha1,
        op_mov_mem_ax   = 8'ha3,
        op_nop          = 8'h90,
        op_hlt          = 8'hf4
    } opcode_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;
    } ls_req_t;

    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        word_t    data;
    } reg_wr_t;

    typedef struct packed {
        logic [byte_w-1:0] data;
        logic              empty;
    } fifo_out_t;

endpackage
